/* rtl/bus_pkg.sv */
package bus_pkg;

	// ======================================================================
	// Memory bus widths
	// ======================================================================

	localparam int BUS_ADDR_W = 32;
	localparam int BUS_DATA_W = 32;

	// ======================================================================
	// Bus access
	// ======================================================================

	// One access on the memory bus.
	// Held stable by the master until the slave strobes ready.
	typedef struct packed {
		// High for a write.
		logic rw;
		logic [BUS_ADDR_W-1:0] address;
		// Ignored on reads.
		logic [BUS_DATA_W-1:0] wdata;
	} bus_req_t;

endpackage

/* rtl/dcache_pkg.sv */
package dcache_pkg;

	// ======================================================================
	// Cache geometry
	// ======================================================================

	// One word per line, direct mapped.
	localparam int INDEX_W = 6;
	localparam int ENTRIES = 1 << INDEX_W;

	// Byte offset inside a word.
	localparam int WORD_OFFSET = 2;
	localparam int WORD_ADDR_W = bus_pkg::BUS_ADDR_W - WORD_OFFSET;

	// Hit and miss counters.
	localparam int COUNT_W = 32;

	// ======================================================================
	// Types
	// ======================================================================

	// Request from the CPU load/store port.
	typedef struct packed {
		logic rw;
		logic flush;
		logic cacheable;
		logic [bus_pkg::BUS_ADDR_W-1:0] address;
		logic [bus_pkg::BUS_DATA_W-1:0] wdata;
	} cpu_req_t;

	// One RAM word, 64 bits.
	// The full word address is kept as the tag.
	typedef struct packed {
		logic [bus_pkg::BUS_DATA_W-1:0] data;
		logic [WORD_ADDR_W-1:0] word_address;
		logic dirty;
		logic valid;
	} cache_entry_t;

	typedef enum logic [1:0] {
		OP_UNCACHED,
		OP_READ,
		OP_WRITE,
		OP_FLUSH
	} dcache_op_t;

	// Controller to result stage, valid each cycle.
	typedef struct packed {
		logic ready;
		// Return bus data instead of entry data.
		logic from_bus;
		logic hit_event;
		logic miss_event;
	} result_ctrl_t;

endpackage

/* rtl/dcache_entry_ram.sv */
`timescale 1ns/1ps

module dcache_entry_ram (
	input logic i_clock,
	input logic i_write,
	input logic [dcache_pkg::INDEX_W-1:0] i_index,
	input dcache_pkg::cache_entry_t i_wdata,
	output dcache_pkg::cache_entry_t o_rdata
);
	import dcache_pkg::*;

	cache_entry_t mem [ENTRIES];

	// Reads every cycle.
	// A write returns the old word on the same edge.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wdata;
		end
		o_rdata <= mem[i_index];
	end

endmodule

/* rtl/dcache_decode.sv */
`timescale 1ns/1ps

module dcache_decode (
	input logic i_request,
	input dcache_pkg::cpu_req_t i_req,
	input dcache_pkg::cache_entry_t i_entry,
	output dcache_pkg::dcache_op_t o_op,
	output logic [dcache_pkg::INDEX_W-1:0] o_index,
	output logic o_hit,
	output logic o_victim_dirty,
	output logic o_any_dirty
);
	import dcache_pkg::*;

	logic [WORD_ADDR_W-1:0] req_word_address;
	logic tag_match;

	// ======================================================================
	// Request classification
	// ======================================================================

	// Flush wins over cacheable, cacheable over uncached.
	always_comb begin
		if (i_req.flush) begin
			o_op = OP_FLUSH;
		end else if (i_req.cacheable) begin
			o_op = i_req.rw ? OP_WRITE : OP_READ;
		end else begin
			o_op = OP_UNCACHED;
		end
	end

	assign o_index = i_req.address[WORD_OFFSET +: INDEX_W];

	// ======================================================================
	// Tag compare
	// ======================================================================

	assign req_word_address = i_req.address[WORD_OFFSET +: WORD_ADDR_W];
	assign tag_match = (i_entry.word_address == req_word_address);

	// Only meaningful while a request is held.
	assign o_hit = i_request && i_entry.valid && tag_match;

	// Another address owns the line and memory is stale.
	assign o_victim_dirty = i_request && i_entry.dirty && !tag_match;

	// Used by the flush walk, which reads by walk index.
	assign o_any_dirty = i_entry.dirty;

endmodule

/* rtl/dcache_control.sv */
`timescale 1ns/1ps

module dcache_control (
	input logic i_clock,
	input logic i_reset,

	// Decoded request.
	input logic i_request,
	input dcache_pkg::dcache_op_t i_op,
	input logic [dcache_pkg::INDEX_W-1:0] i_index,
	input logic i_hit,
	input logic i_victim_dirty,
	input logic i_any_dirty,
	input dcache_pkg::cpu_req_t i_req,
	input dcache_pkg::cache_entry_t i_entry,

	// Memory bus.
	input logic i_bus_ready,
	input logic [bus_pkg::BUS_DATA_W-1:0] i_bus_rdata,
	output logic o_bus_request,
	output bus_pkg::bus_req_t o_bus_req,

	// Entry RAM.
	output logic o_ram_write,
	output logic [dcache_pkg::INDEX_W-1:0] o_ram_index,
	output dcache_pkg::cache_entry_t o_ram_wdata,

	output dcache_pkg::result_ctrl_t o_result
);
	import bus_pkg::*;
	import dcache_pkg::*;

	typedef enum logic [3:0] {
		INITIALIZE,
		IDLE,
		PASS_THROUGH,
		READ_CHECK,
		READ_WRITEBACK,
		READ_FILL,
		WRITE_CHECK,
		WRITE_WRITEBACK,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE
	} state_t;

	state_t state;
	state_t next_state;

	// Shared by the initialize and flush walks.
	logic [INDEX_W-1:0] walk_index;
	logic [INDEX_W-1:0] next_walk_index;
	logic walk_last;

	assign walk_last = &walk_index;

	// Bus write of the entry currently out of the RAM.
	function automatic bus_req_t writeback_req(input cache_entry_t entry);
		bus_req_t req;
		req.rw = 1'b1;
		req.address = {entry.word_address, {WORD_OFFSET{1'b0}}};
		req.wdata = entry.data;
		return req;
	endfunction

	function automatic cache_entry_t make_entry(
		input logic [BUS_DATA_W-1:0] data,
		input logic [BUS_ADDR_W-1:0] address,
		input logic dirty
	);
		cache_entry_t entry;
		entry.data = data;
		entry.word_address = address[WORD_OFFSET +: WORD_ADDR_W];
		entry.dirty = dirty;
		entry.valid = 1'b1;
		return entry;
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			walk_index <= '0;
		end else begin
			state <= next_state;
			walk_index <= next_walk_index;
		end
	end

	always_comb begin
		next_state = state;
		next_walk_index = walk_index;
		o_bus_request = 1'b0;
		o_bus_req = '0;
		// RAM follows the request unless a walk is running.
		o_ram_write = 1'b0;
		o_ram_index = i_index;
		o_ram_wdata = '0;
		o_result = '0;

		case (state)
			// Clear one entry per cycle.
			INITIALIZE: begin
				o_ram_write = 1'b1;
				o_ram_index = walk_index;
				next_walk_index = walk_index + 1'b1;
				if (walk_last) begin
					next_state = IDLE;
				end
			end

			// The RAM reads the request index at this edge.
			IDLE: begin
				if (i_request) begin
					case (i_op)
						OP_FLUSH: begin
							next_walk_index = '0;
							next_state = FLUSH_SETUP;
						end
						OP_READ: next_state = READ_CHECK;
						OP_WRITE: next_state = WRITE_CHECK;
						default: next_state = PASS_THROUGH;
					endcase
				end
			end

			PASS_THROUGH: begin
				o_bus_request = i_request;
				o_bus_req.rw = i_req.rw;
				o_bus_req.address = i_req.address;
				o_bus_req.wdata = i_req.wdata;
				o_result.ready = i_bus_ready;
				o_result.from_bus = 1'b1;
				if (i_bus_ready || !i_request) begin
					next_state = IDLE;
				end
			end

			// ==================================================================
			// Read
			// ==================================================================

			READ_CHECK: begin
				if (i_hit) begin
					o_result.ready = 1'b1;
					o_result.hit_event = 1'b1;
					next_state = IDLE;
				end else begin
					o_result.miss_event = 1'b1;
					next_state = i_victim_dirty ? READ_WRITEBACK : READ_FILL;
				end
			end

			READ_WRITEBACK: begin
				o_bus_request = 1'b1;
				o_bus_req = writeback_req(i_entry);
				if (i_bus_ready) begin
					next_state = READ_FILL;
				end
			end

			READ_FILL: begin
				o_bus_request = 1'b1;
				o_bus_req.address = i_req.address;
				o_result.from_bus = 1'b1;
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_ram_wdata = make_entry(i_bus_rdata, i_req.address, 1'b0);
					o_result.ready = 1'b1;
					next_state = IDLE;
				end
			end

			// ==================================================================
			// Write
			// ==================================================================

			WRITE_CHECK: begin
				if (i_victim_dirty) begin
					o_result.miss_event = 1'b1;
					next_state = WRITE_WRITEBACK;
				end else begin
					o_ram_write = 1'b1;
					o_ram_wdata = make_entry(i_req.wdata, i_req.address, 1'b1);
					o_result.ready = 1'b1;
					o_result.hit_event = 1'b1;
					next_state = IDLE;
				end
			end

			WRITE_WRITEBACK: begin
				o_bus_request = 1'b1;
				o_bus_req = writeback_req(i_entry);
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_ram_wdata = make_entry(i_req.wdata, i_req.address, 1'b1);
					o_result.ready = 1'b1;
					next_state = IDLE;
				end
			end

			// ==================================================================
			// Flush
			// ==================================================================

			// Present the walk index, entry arrives next cycle.
			FLUSH_SETUP: begin
				o_ram_index = walk_index;
				next_state = FLUSH_CHECK;
			end

			FLUSH_CHECK: begin
				o_ram_index = walk_index;
				if (i_any_dirty) begin
					next_state = FLUSH_WRITE;
				end else if (walk_last) begin
					o_result.ready = 1'b1;
					next_state = IDLE;
				end else begin
					// Clean entry, read the next one straight away.
					o_ram_index = walk_index + 1'b1;
					next_walk_index = walk_index + 1'b1;
				end
			end

			FLUSH_WRITE: begin
				o_ram_index = walk_index;
				o_bus_request = 1'b1;
				o_bus_req = writeback_req(i_entry);
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_ram_wdata = i_entry;
					o_ram_wdata.dirty = 1'b0;
					next_walk_index = walk_index + 1'b1;
					if (walk_last) begin
						o_result.ready = 1'b1;
						next_state = IDLE;
					end else begin
						next_state = FLUSH_SETUP;
					end
				end
			end

			default: next_state = IDLE;
		endcase
	end

endmodule

/* rtl/dcache_response.sv */
`timescale 1ns/1ps

module dcache_response (
	input logic i_clock,
	input logic i_reset,
	input dcache_pkg::result_ctrl_t i_result,
	input logic [bus_pkg::BUS_DATA_W-1:0] i_entry_data,
	input logic [bus_pkg::BUS_DATA_W-1:0] i_bus_rdata,
	output logic o_ready,
	output logic [bus_pkg::BUS_DATA_W-1:0] o_rdata,
	output logic [dcache_pkg::COUNT_W-1:0] o_hits,
	output logic [dcache_pkg::COUNT_W-1:0] o_misses
);

	// ======================================================================
	// Read data and ready
	// ======================================================================

	assign o_ready = i_result.ready;

	// Fill and uncached reads return bus data, hits return the entry.
	assign o_rdata = i_result.from_bus ? i_bus_rdata : i_entry_data;

	// ======================================================================
	// Counters
	// ======================================================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hits <= '0;
		end else if (i_result.hit_event) begin
			o_hits <= o_hits + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_misses <= '0;
		end else if (i_result.miss_event) begin
			o_misses <= o_misses + 1'b1;
		end
	end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
	input logic i_clock,
	input logic i_reset,

	// CPU side.
	input logic i_request,
	input dcache_pkg::cpu_req_t i_req,
	output logic o_ready,
	output logic [bus_pkg::BUS_DATA_W-1:0] o_rdata,

	// Bus side.
	output logic o_bus_request,
	output bus_pkg::bus_req_t o_bus_req,
	input logic i_bus_ready,
	input logic [bus_pkg::BUS_DATA_W-1:0] i_bus_rdata,

	output logic [dcache_pkg::COUNT_W-1:0] o_hits,
	output logic [dcache_pkg::COUNT_W-1:0] o_misses
);
	import dcache_pkg::*;

	dcache_op_t op;
	logic [INDEX_W-1:0] index;
	logic hit;
	logic victim_dirty;
	logic any_dirty;

	logic ram_write;
	logic [INDEX_W-1:0] ram_index;
	cache_entry_t ram_wdata;
	cache_entry_t entry;

	result_ctrl_t result;

	dcache_entry_ram dcache_entry_ram_inst (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_index(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(entry)
	);

	dcache_decode dcache_decode_inst (
		.i_request(i_request),
		.i_req(i_req),
		.i_entry(entry),
		.o_op(op),
		.o_index(index),
		.o_hit(hit),
		.o_victim_dirty(victim_dirty),
		.o_any_dirty(any_dirty)
	);

	dcache_control dcache_control_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_op(op),
		.i_index(index),
		.i_hit(hit),
		.i_victim_dirty(victim_dirty),
		.i_any_dirty(any_dirty),
		.i_req(i_req),
		.i_entry(entry),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_req(o_bus_req),
		.o_ram_write(ram_write),
		.o_ram_index(ram_index),
		.o_ram_wdata(ram_wdata),
		.o_result(result)
	);

	dcache_response dcache_response_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_result(result),
		.i_entry_data(entry.data),
		.i_bus_rdata(i_bus_rdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_hits(o_hits),
		.o_misses(o_misses)
	);

endmodule

/* verification/dcache_tb_memory.sv */
`timescale 1ns/1ps

module dcache_tb_memory (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input bus_pkg::bus_req_t i_bus_req,
	output logic o_bus_ready,
	output logic [bus_pkg::BUS_DATA_W-1:0] o_bus_rdata,
	output logic [31:0] o_write_count
);
	import bus_pkg::*;

	localparam int WORD_INDEX_W = 10;
	localparam int WORDS = 1 << WORD_INDEX_W;

	logic [BUS_DATA_W-1:0] words [WORDS];
	logic [WORD_INDEX_W-1:0] word_index;
	logic [31:0] lcg_state;
	logic [1:0] wait_cycles;
	logic busy;

	function automatic logic [31:0] lcg_step(input logic [31:0] value);
		return value * 32'd1664525 + 32'd1013904223;
	endfunction

	// Contents depend on every bit of the word index.
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			words[WORD_INDEX_W'(i)] <= (32'(i) * 32'h0100_0193) ^ 32'hc0de_5a5a;
		end
	end

	assign word_index = i_bus_req.address[WORD_INDEX_W+1:2];

	always @(posedge i_clock) begin
		o_bus_ready <= 1'b0;
		if (i_reset) begin
			busy <= 1'b0;
			wait_cycles <= '0;
			o_bus_rdata <= '0;
			o_write_count <= '0;
			lcg_state <= 32'ha79f578c;
		end else if (busy) begin
			if (wait_cycles == 2'd0) begin
				busy <= 1'b0;
				o_bus_ready <= 1'b1;
				if (i_bus_req.rw) begin
					words[word_index] <= i_bus_req.wdata;
					o_write_count <= o_write_count + 1;
				end else begin
					o_bus_rdata <= words[word_index];
				end
			end else begin
				wait_cycles <= wait_cycles - 1'b1;
			end
		end else if (i_bus_request && !o_bus_ready) begin
			// New access, answered one to four cycles later.
			busy <= 1'b1;
			wait_cycles <= lcg_state[17:16];
			lcg_state <= lcg_step(lcg_state);
		end
	end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
	import bus_pkg::*;
	import dcache_pkg::*;

	localparam int WORD_INDEX_W = 10;
	localparam int WORDS = 1 << WORD_INDEX_W;
	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_REQUESTS = 24;
	localparam int RANDOM_REQUESTS = 200;
	localparam int TIMEOUT_CYCLES =
		(DIRECTED_REQUESTS + RANDOM_REQUESTS) * 40 + RESET_CYCLES + ENTRIES;

	logic clock;
	logic reset;
	logic request;
	cpu_req_t cpu_req;
	logic ready;
	logic [BUS_DATA_W-1:0] rdata;
	logic bus_request;
	bus_req_t bus_req;
	logic bus_ready;
	logic [BUS_DATA_W-1:0] bus_rdata;
	logic [COUNT_W-1:0] hits;
	logic [COUNT_W-1:0] misses;
	logic [31:0] write_count;
	logic [31:0] bus_request_cycles;

	// Shadow of memory and of the cache table.
	logic [BUS_DATA_W-1:0] shadow_mem [WORDS];
	logic [BUS_DATA_W-1:0] shadow_data [ENTRIES];
	logic [WORD_ADDR_W-1:0] shadow_tag [ENTRIES];
	logic shadow_valid [ENTRIES];
	logic shadow_dirty [ENTRIES];
	logic [COUNT_W-1:0] expected_hits;
	logic [COUNT_W-1:0] expected_misses;
	logic [31:0] expected_writes;
	logic [31:0] rand_state;

	dcache_top dcache_top_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_req(cpu_req),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_bus_request(bus_request),
		.o_bus_req(bus_req),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.o_hits(hits),
		.o_misses(misses)
	);

	dcache_tb_memory dcache_tb_memory_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_bus_request(bus_request),
		.i_bus_req(bus_req),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata),
		.o_write_count(write_count)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	// Cycles in which the cache raises a bus request.
	always @(posedge clock) begin
		if (reset) begin
			bus_request_cycles <= '0;
		end else if (bus_request) begin
			bus_request_cycles <= bus_request_cycles + 1;
		end
	end

	// ======================================================================
	// Failure handling and compare tasks
	// ======================================================================

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_word(input string what, input logic [BUS_DATA_W-1:0] actual,
			input logic [BUS_DATA_W-1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_counters(input logic [COUNT_W-1:0] actual_hits,
			input logic [COUNT_W-1:0] actual_misses);
		if (actual_hits !== expected_hits || actual_misses !== expected_misses) begin
			abort_run($sformatf("[ERROR] %0t: hits %0d misses %0d, expected %0d and %0d",
				$time, actual_hits, actual_misses, expected_hits, expected_misses));
		end
	endtask

	task automatic verify_memory();
		for (int i = 0; i < WORDS; i++) begin
			check_word($sformatf("memory word %0d", i),
				dcache_tb_memory_inst.words[WORD_INDEX_W'(i)], shadow_mem[WORD_INDEX_W'(i)]);
		end
	endtask

	// ======================================================================
	// Stimulus and shadow model
	// ======================================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] value);
		return value * 32'd1664525 + 32'd1013904223;
	endfunction

	// Same fill as the bus memory.
	function automatic logic [BUS_DATA_W-1:0] initial_word(input logic [31:0] index);
		return (index * 32'h0100_0193) ^ 32'hc0de_5a5a;
	endfunction

	function automatic cpu_req_t make_req(input logic rw, input logic flush,
			input logic cacheable, input logic [BUS_ADDR_W-1:0] address,
			input logic [BUS_DATA_W-1:0] wdata);
		cpu_req_t req;
		req.rw = rw;
		req.flush = flush;
		req.cacheable = cacheable;
		req.address = address;
		req.wdata = wdata;
		return req;
	endfunction

	// Hold the request until the ready strobe and drop it on that edge.
	task automatic access(input cpu_req_t req, output logic [BUS_DATA_W-1:0] data);
		@(posedge clock);
		request <= 1'b1;
		cpu_req <= req;
		do begin
			@(negedge clock);
		end while (!ready);
		data = rdata;
		@(posedge clock);
		request <= 1'b0;
		@(negedge clock);
	endtask

	task automatic write_back_victim(input logic [INDEX_W-1:0] index,
			input logic [WORD_ADDR_W-1:0] word);
		if (shadow_dirty[index] && shadow_tag[index] != word) begin
			shadow_mem[shadow_tag[index][WORD_INDEX_W-1:0]] = shadow_data[index];
			expected_writes = expected_writes + 1;
		end
	endtask

	task automatic cached_read(input logic [BUS_ADDR_W-1:0] address);
		logic [WORD_ADDR_W-1:0] word;
		logic [INDEX_W-1:0] index;
		logic [BUS_DATA_W-1:0] data;
		word = address[BUS_ADDR_W-1:WORD_OFFSET];
		index = word[INDEX_W-1:0];
		if (shadow_valid[index] && shadow_tag[index] == word) begin
			expected_hits = expected_hits + 1;
		end else begin
			expected_misses = expected_misses + 1;
			write_back_victim(index, word);
			shadow_data[index] = shadow_mem[word[WORD_INDEX_W-1:0]];
			shadow_tag[index] = word;
			shadow_valid[index] = 1'b1;
			shadow_dirty[index] = 1'b0;
		end
		access(make_req(1'b0, 1'b0, 1'b1, address, '0), data);
		check_word($sformatf("cached read of %h", address), data, shadow_data[index]);
	endtask

	task automatic cached_write(input logic [BUS_ADDR_W-1:0] address,
			input logic [BUS_DATA_W-1:0] wdata);
		logic [WORD_ADDR_W-1:0] word;
		logic [INDEX_W-1:0] index;
		logic [BUS_DATA_W-1:0] data;
		word = address[BUS_ADDR_W-1:WORD_OFFSET];
		index = word[INDEX_W-1:0];
		// Only a dirty victim makes a write a miss.
		if (shadow_dirty[index] && shadow_tag[index] != word) begin
			expected_misses = expected_misses + 1;
		end else begin
			expected_hits = expected_hits + 1;
		end
		write_back_victim(index, word);
		shadow_data[index] = wdata;
		shadow_tag[index] = word;
		shadow_valid[index] = 1'b1;
		shadow_dirty[index] = 1'b1;
		access(make_req(1'b1, 1'b0, 1'b1, address, wdata), data);
	endtask

	task automatic uncached_access(input logic rw, input logic [BUS_ADDR_W-1:0] address,
			input logic [BUS_DATA_W-1:0] wdata);
		logic [BUS_DATA_W-1:0] data;
		access(make_req(rw, 1'b0, 1'b0, address, wdata), data);
		if (rw) begin
			shadow_mem[address[WORD_INDEX_W+1:2]] = wdata;
			expected_writes = expected_writes + 1;
		end else begin
			check_word($sformatf("uncached read of %h", address), data,
				shadow_mem[address[WORD_INDEX_W+1:2]]);
		end
	endtask

	task automatic flush_cache();
		logic [BUS_DATA_W-1:0] data;
		for (int i = 0; i < ENTRIES; i++) begin
			if (shadow_dirty[INDEX_W'(i)]) begin
				shadow_mem[shadow_tag[INDEX_W'(i)][WORD_INDEX_W-1:0]] = shadow_data[INDEX_W'(i)];
				shadow_dirty[INDEX_W'(i)] = 1'b0;
				expected_writes = expected_writes + 1;
			end
		end
		access(make_req(1'b0, 1'b1, 1'b0, '0, '0), data);
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic read_miss_then_hit();
		logic [31:0] request_cycles;
		cached_read(32'h0000_0040);
		request_cycles = bus_request_cycles;
		cached_read(32'h0000_0040);
		check_word("bus request cycles during a read hit", bus_request_cycles,
			request_cycles);
		check_counters(hits, misses);
	endtask

	task automatic write_then_read();
		logic [31:0] writes;
		writes = write_count;
		cached_write(32'h0000_0084, 32'h1234_5678);
		cached_read(32'h0000_0084);
		check_word("bus writes after a cached write", write_count, writes);
		check_counters(hits, misses);
	endtask

	// Same index with tags one cache size apart.
	task automatic conflict_writeback();
		cached_write(32'h0000_00c8, 32'hdead_0001);
		cached_write(32'h0000_01c8, 32'hbeef_0002);
		check_word("written back word", dcache_tb_memory_inst.words[10'h032], 32'hdead_0001);
		cached_read(32'h0000_00c8);
		check_counters(hits, misses);
		check_word("bus write count", write_count, expected_writes);
	endtask

	task automatic uncached_bypass();
		uncached_access(1'b0, 32'h0000_0300, '0);
		uncached_access(1'b1, 32'h0000_0304, 32'h0bad_cafe);
		uncached_access(1'b0, 32'h0000_0304, '0);
		check_counters(hits, misses);
		check_word("bus write count", write_count, expected_writes);
	endtask

	task automatic flush_dirty_entries();
		logic [31:0] dirty_entries;
		logic [31:0] writes;
		for (int k = 0; k < 8; k++) begin
			cached_write(32'h0000_0200 + 32'(k * 4), 32'h5000_0000 + 32'(k));
		end
		dirty_entries = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			if (shadow_dirty[INDEX_W'(i)]) begin
				dirty_entries = dirty_entries + 1;
			end
		end
		writes = write_count;
		flush_cache();
		check_word("bus writes during flush", write_count - writes, dirty_entries);
		verify_memory();
		writes = write_count;
		flush_cache();
		check_word("bus writes during a second flush", write_count - writes, '0);
	endtask

	task automatic random_mix();
		logic [5:0] kind;
		logic [BUS_ADDR_W-1:0] address;
		logic [BUS_DATA_W-1:0] wdata;
		for (int n = 0; n < RANDOM_REQUESTS; n++) begin
			rand_state = lcg_next(rand_state);
			kind = rand_state[31:26];
			address = {22'd0, rand_state[23:16], 2'b00};
			rand_state = lcg_next(rand_state);
			wdata = rand_state;
			if (kind == 6'd0) begin
				flush_cache();
			end else if (kind < 6'd6) begin
				uncached_access(kind[0], address, wdata);
			end else if (kind[0]) begin
				cached_write(address, wdata);
			end else begin
				cached_read(address);
			end
		end
		check_counters(hits, misses);
		flush_cache();
		verify_memory();
		check_word("bus write count", write_count, expected_writes);
	endtask

	// Ends the run if the tests stall.
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		abort_run($sformatf("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		reset <= 1'b1;
		request <= 1'b0;
		cpu_req <= '0;
		rand_state = 32'ha79f578c;
		expected_hits = '0;
		expected_misses = '0;
		expected_writes = '0;
		for (int i = 0; i < WORDS; i++) begin
			shadow_mem[WORD_INDEX_W'(i)] = initial_word(32'(i));
		end
		for (int i = 0; i < ENTRIES; i++) begin
			shadow_data[INDEX_W'(i)] = '0;
			shadow_tag[INDEX_W'(i)] = '0;
			shadow_valid[INDEX_W'(i)] = 1'b0;
			shadow_dirty[INDEX_W'(i)] = 1'b0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		read_miss_then_hit();
		write_then_read();
		conflict_writeback();
		uncached_bypass();
		flush_dirty_entries();
		random_mix();

		$display("All checks passed");
		$finish;
	end

endmodule

/* files.f */
rtl/bus_pkg.sv
rtl/dcache_pkg.sv
rtl/dcache_entry_ram.sv
rtl/dcache_decode.sv
rtl/dcache_control.sv
rtl/dcache_response.sv
rtl/dcache_top.sv
verification/dcache_tb_memory.sv
verification/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# A $fatal in the testbench gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module dcache_tb \
	-f files.f

./obj_dir/Vdcache_tb
